/* logic/dacfifo_cfg.svh */
// ***************************************************************************
// build-time sizes of the DAC playback buffer
// sample and memory word widths, waveform base address, prefetch depth
// ***************************************************************************

`ifndef DACFIFO_CFG_SVH
`define DACFIFO_CFG_SVH

// two DMA samples share one memory word
`define DACFIFO_DMA_WIDTH       64
`define DACFIFO_AVL_WIDTH       128
`define DACFIFO_AVL_ADDR_WIDTH  10

`define DACFIFO_BASE_ADDRESS    10'h040

// words held on the output side, power of two
`define DACFIFO_PREFETCH_DEPTH  4

`endif

/* logic/dacfifo_pkg.sv */
// ***************************************************************************
// shared types of the DAC playback buffer
// sample, memory word and address types, state and grant enums
// ***************************************************************************

`default_nettype none

`include "dacfifo_cfg.svh"

package dacfifo_pkg;

  typedef logic [`DACFIFO_DMA_WIDTH-1:0]      sample_t;
  // low half holds the earlier sample
  typedef logic [`DACFIFO_AVL_WIDTH-1:0]      avl_word_t;
  typedef logic [`DACFIFO_AVL_ADDR_WIDTH-1:0] avl_addr_t;

  // owner of the memory port
  typedef enum logic [1:0] {op_idle, op_write, op_read} avl_op_e;

  typedef enum logic [1:0] {wr_idle, wr_fill, wr_flush, wr_done} wr_state_e;

  typedef enum logic {rd_idle, rd_play} rd_state_e;

endpackage

`default_nettype wire

/* logic/avl_req_if.sv */
// ***************************************************************************
// memory request bundle of one requester
// single word request, acknowledge and read response
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

interface avl_req_if import dacfifo_pkg::*; ();

  // request side, held until grant_ack
  logic       req;
  avl_addr_t  address;
  avl_word_t  writedata;

  // response side
  logic       grant_ack;
  avl_word_t  readdata;
  logic       readdata_valid;

  modport requester (
    output req, address, writedata,
    input  grant_ack, readdata, readdata_valid
  );

  modport arbiter (
    input  req, address, writedata,
    output grant_ack, readdata, readdata_valid
  );

endinterface

`default_nettype wire

/* logic/dma_wr_side.sv */
// ***************************************************************************
// input side of the playback buffer
// packs DMA sample pairs into memory words and writes them upwards
// from the base address, then publishes the end of the waveform
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "dacfifo_cfg.svh"

module dma_wr_side import dacfifo_pkg::*; (
  input  logic               dac_clk,
  input  logic               avl_reset,
  input  logic               dma_valid,
  input  sample_t            dma_data,
  output logic               dma_ready,
  input  logic               dma_xfer_req,
  input  logic               dma_xfer_last,
  avl_req_if.requester       wr_bus,
  output avl_addr_t          last_addr,
  output logic               last_odd,
  output logic               wave_ready
);

  wr_state_e  state;
  logic       xfer_req_d;
  logic       xfer_rise;
  logic       beat;
  // low half of wr_word already holds a sample
  logic       half;
  logic       odd_q;
  logic       req;
  avl_addr_t  wr_addr;
  avl_addr_t  req_addr;
  avl_word_t  wr_word;

  assign xfer_rise = dma_xfer_req & ~xfer_req_d;

  // no room while a packed word waits for its write
  assign dma_ready = dma_xfer_req & xfer_req_d & (state == wr_fill) & ~req;
  assign beat = dma_valid & dma_ready;

  assign wr_bus.req = req;
  assign wr_bus.address = req_addr;
  assign wr_bus.writedata = wr_word;

  // ************************************************************************
  // control
  // ************************************************************************

  always_ff @(posedge dac_clk) begin
    if (avl_reset) begin
      state <= wr_idle;
      xfer_req_d <= 1'b0;
      half <= 1'b0;
      odd_q <= 1'b0;
      req <= 1'b0;
      wr_addr <= `DACFIFO_BASE_ADDRESS;
      last_addr <= `DACFIFO_BASE_ADDRESS;
      last_odd <= 1'b0;
      wave_ready <= 1'b0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      wave_ready <= 1'b0;
      if (wr_bus.grant_ack) begin
        req <= 1'b0;
      end
      if (xfer_rise) begin
        // new transfer drops the old waveform
        state <= wr_fill;
        half <= 1'b0;
        wr_addr <= `DACFIFO_BASE_ADDRESS;
      end else begin
        case (state)
          wr_fill: begin
            if (beat) begin
              half <= ~half;
              if (half | dma_xfer_last) begin
                req <= 1'b1;
                wr_addr <= wr_addr + 1'b1;
              end
              if (dma_xfer_last) begin
                odd_q <= ~half;
                state <= wr_flush;
              end
            end
          end
          wr_flush: begin
            // only the final word can be pending here
            if (wr_bus.grant_ack) begin
              last_addr <= req_addr;
              last_odd <= odd_q;
              wave_ready <= 1'b1;
              state <= wr_done;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  // packing register, an even beat clears the upper half
  always_ff @(posedge dac_clk) begin
    if (beat) begin
      if (half) begin
        wr_word[`DACFIFO_DMA_WIDTH +: `DACFIFO_DMA_WIDTH] <= dma_data;
      end else begin
        wr_word <= avl_word_t'(dma_data);
      end
    end
    if (beat && (half || dma_xfer_last)) begin
      req_addr <= wr_addr;
    end
  end

  // a pending word stays untouched until the arbiter takes it
  assert property (@(posedge dac_clk) disable iff (avl_reset)
    (req && !wr_bus.grant_ack) |=> (req && $stable({req_addr, wr_word})));

endmodule

`default_nettype wire

/* logic/avl_port_arbiter.sv */
// ***************************************************************************
// memory port arbiter
// writer first, registered Avalon outputs, in-order read return
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

module avl_port_arbiter import dacfifo_pkg::*; (
  input  logic               dac_clk,
  input  logic               avl_reset,
  avl_req_if.arbiter         wr_bus,
  avl_req_if.arbiter         rd_bus,
  output avl_addr_t          avl_address,
  output logic               avl_read,
  output logic               avl_write,
  output avl_word_t          avl_writedata,
  input  logic               avl_ready,
  input  avl_word_t          avl_readdata,
  input  logic               avl_readdata_valid
);

  avl_op_e  grant;
  logic     busy;

  // an access sits on the bus until avl_ready takes it
  assign busy = avl_read | avl_write;

  always_comb begin
    grant = op_idle;
    if (!busy) begin
      if (wr_bus.req) begin
        grant = op_write;
      end else if (rd_bus.req) begin
        grant = op_read;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (avl_reset) begin
      avl_read <= 1'b0;
      avl_write <= 1'b0;
    end else if (busy) begin
      if (avl_ready) begin
        avl_read <= 1'b0;
        avl_write <= 1'b0;
      end
    end else begin
      avl_write <= (grant == op_write);
      avl_read <= (grant == op_read);
    end
  end

  always_ff @(posedge dac_clk) begin
    case (grant)
      op_write: begin
        avl_address <= wr_bus.address;
        avl_writedata <= wr_bus.writedata;
      end
      op_read: begin
        avl_address <= rd_bus.address;
      end
      default: begin
      end
    endcase
  end

  assign wr_bus.grant_ack = avl_write & avl_ready;
  assign rd_bus.grant_ack = avl_read & avl_ready;

  // responses go to the reader, the writer never reads
  assign wr_bus.readdata = avl_readdata;
  assign wr_bus.readdata_valid = 1'b0;
  assign rd_bus.readdata = avl_readdata;
  assign rd_bus.readdata_valid = avl_readdata_valid;

  assert property (@(posedge dac_clk) disable iff (avl_reset)
    !(avl_read && avl_write));

  assert property (@(posedge dac_clk) disable iff (avl_reset)
    (busy && !avl_ready) |=> $stable({avl_read, avl_write, avl_address, avl_writedata}));

endmodule

`default_nettype wire

/* logic/dac_rd_side.sv */
// ***************************************************************************
// output side of the playback buffer
// cyclic word prefetch under buffer credit, unpacking into samples,
// DAC strobe handling with underflow flag
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "dacfifo_cfg.svh"

module dac_rd_side import dacfifo_pkg::*; (
  input  logic               dac_clk,
  input  logic               avl_reset,
  input  logic               dma_xfer_req,
  input  avl_addr_t          last_addr,
  input  logic               last_odd,
  input  logic               wave_ready,
  avl_req_if.requester       rd_bus,
  input  logic               dac_valid,
  output sample_t            dac_data,
  output logic               dac_dunf,
  output logic               dac_xfer_out
);

  localparam int DEPTH = `DACFIFO_PREFETCH_DEPTH;
  localparam int PW = $clog2(DEPTH);
  localparam int CW = PW + 1;
  localparam int SW = `DACFIFO_DMA_WIDTH;

  rd_state_e        state;
  logic             xfer_req_d;
  logic             xfer_rise;
  logic             req;
  avl_addr_t        rd_addr;
  avl_addr_t        req_addr;
  avl_addr_t        ret_addr;
  // reads of the current waveform still out
  logic [CW-1:0]    inflight;
  // reads of an aborted waveform, thrown away on return
  logic [CW-1:0]    drop_cnt;
  logic [CW-1:0]    buf_cnt;
  logic [CW-1:0]    credit_used;
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic             half_sel;
  avl_word_t        buf_mem [DEPTH];
  logic [DEPTH-1:0] buf_two;
  logic             issue;
  logic             live_ret;
  logic             stale_ret;
  logic             take;
  logic             pop_word;

  // next word address, wraps after the last word of the waveform
  function automatic avl_addr_t step_addr(input avl_addr_t addr, input avl_addr_t last);
    return (addr == last) ? avl_addr_t'(`DACFIFO_BASE_ADDRESS) : addr + 1'b1;
  endfunction

  assign xfer_rise = dma_xfer_req & ~xfer_req_d;
  assign credit_used = buf_cnt + inflight + drop_cnt;
  assign issue = (state == rd_play) & ~req & ~xfer_rise & (credit_used < CW'(DEPTH));
  assign stale_ret = rd_bus.readdata_valid & (drop_cnt != '0);
  assign live_ret = rd_bus.readdata_valid & (drop_cnt == '0);

  // a word with one sample leaves on its first pop
  assign take = dac_valid & (buf_cnt != '0);
  assign pop_word = take & (half_sel | ~buf_two[rd_ptr]);

  assign rd_bus.req = req;
  assign rd_bus.address = req_addr;
  assign rd_bus.writedata = '0;
  assign dac_xfer_out = (state == rd_play);

  // ************************************************************************
  // control
  // ************************************************************************

  always_ff @(posedge dac_clk) begin
    if (avl_reset) begin
      state <= rd_idle;
      xfer_req_d <= 1'b0;
      req <= 1'b0;
      rd_addr <= `DACFIFO_BASE_ADDRESS;
      ret_addr <= `DACFIFO_BASE_ADDRESS;
      inflight <= '0;
      drop_cnt <= '0;
      buf_cnt <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      half_sel <= 1'b0;
      dac_dunf <= 1'b0;
    end else begin
      xfer_req_d <= dma_xfer_req;
      dac_dunf <= dac_valid & (state == rd_play) & (buf_cnt == '0);
      if (rd_bus.grant_ack) begin
        req <= 1'b0;
      end
      if (issue) begin
        req <= 1'b1;
        rd_addr <= step_addr(rd_addr, last_addr);
      end
      if (xfer_rise) begin
        // stop playing, everything still out becomes stale
        state <= rd_idle;
        drop_cnt <= drop_cnt + inflight - CW'(rd_bus.readdata_valid);
        inflight <= '0;
        buf_cnt <= '0;
        wr_ptr <= '0;
        rd_ptr <= '0;
        half_sel <= 1'b0;
      end else begin
        if (wave_ready) begin
          state <= rd_play;
          rd_addr <= `DACFIFO_BASE_ADDRESS;
          ret_addr <= `DACFIFO_BASE_ADDRESS;
        end
        inflight <= inflight + CW'(issue) - CW'(live_ret);
        drop_cnt <= drop_cnt - CW'(stale_ret);
        buf_cnt <= buf_cnt + CW'(live_ret) - CW'(pop_word);
        if (live_ret) begin
          wr_ptr <= wr_ptr + 1'b1;
          ret_addr <= step_addr(ret_addr, last_addr);
        end
        if (take) begin
          half_sel <= ~pop_word;
        end
        if (pop_word) begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // ************************************************************************
  // word buffer and sample output
  // ************************************************************************

  always_ff @(posedge dac_clk) begin
    if (issue) begin
      req_addr <= rd_addr;
    end
    if (live_ret) begin
      buf_mem[wr_ptr] <= rd_bus.readdata;
      buf_two[wr_ptr] <= ~(last_odd & (ret_addr == last_addr));
    end
    // held on underflow
    if (take) begin
      dac_data <= half_sel ? buf_mem[rd_ptr][SW +: SW] : buf_mem[rd_ptr][0 +: SW];
    end
  end

  // credit covers every word that can still come back
  assert property (@(posedge dac_clk) disable iff (avl_reset)
    live_ret |-> (buf_cnt < CW'(DEPTH)));

endmodule

`default_nettype wire

/* logic/avl_dacfifo.sv */
// ***************************************************************************
// DAC playback buffer on external memory, top level
// input side, port arbiter and output side on one clock
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "dacfifo_cfg.svh"

module avl_dacfifo (
  input  logic                                dac_clk,
  input  logic                                avl_reset,

  // dma interface
  input  logic                                dma_valid,
  input  logic [`DACFIFO_DMA_WIDTH-1:0]       dma_data,
  output logic                                dma_ready,
  input  logic                                dma_xfer_req,
  input  logic                                dma_xfer_last,

  // dac interface
  input  logic                                dac_valid,
  output logic [`DACFIFO_DMA_WIDTH-1:0]       dac_data,
  output logic                                dac_dunf,
  output logic                                dac_xfer_out,

  // avalon interface
  output logic [`DACFIFO_AVL_ADDR_WIDTH-1:0]  avl_address,
  output logic                                avl_read,
  output logic                                avl_write,
  output logic [`DACFIFO_AVL_WIDTH-1:0]       avl_writedata,
  input  logic                                avl_ready,
  input  logic [`DACFIFO_AVL_WIDTH-1:0]       avl_readdata,
  input  logic                                avl_readdata_valid
);

  // end of the stored waveform, handed from input to output side
  logic [`DACFIFO_AVL_ADDR_WIDTH-1:0] last_addr;
  logic                               last_odd;
  logic                               wave_ready;

  avl_req_if wr_bus ();
  avl_req_if rd_bus ();

  dma_wr_side i_wr (
    .dac_clk        (dac_clk),
    .avl_reset      (avl_reset),
    .dma_valid      (dma_valid),
    .dma_data       (dma_data),
    .dma_ready      (dma_ready),
    .dma_xfer_req   (dma_xfer_req),
    .dma_xfer_last  (dma_xfer_last),
    .wr_bus         (wr_bus.requester),
    .last_addr      (last_addr),
    .last_odd       (last_odd),
    .wave_ready     (wave_ready)
  );

  avl_port_arbiter i_arb (
    .dac_clk            (dac_clk),
    .avl_reset          (avl_reset),
    .wr_bus             (wr_bus.arbiter),
    .rd_bus             (rd_bus.arbiter),
    .avl_address        (avl_address),
    .avl_read           (avl_read),
    .avl_write          (avl_write),
    .avl_writedata      (avl_writedata),
    .avl_ready          (avl_ready),
    .avl_readdata       (avl_readdata),
    .avl_readdata_valid (avl_readdata_valid)
  );

  dac_rd_side i_rd (
    .dac_clk        (dac_clk),
    .avl_reset      (avl_reset),
    .dma_xfer_req   (dma_xfer_req),
    .last_addr      (last_addr),
    .last_odd       (last_odd),
    .wave_ready     (wave_ready),
    .rd_bus         (rd_bus.requester),
    .dac_valid      (dac_valid),
    .dac_data       (dac_data),
    .dac_dunf       (dac_dunf),
    .dac_xfer_out   (dac_xfer_out)
  );

endmodule

`default_nettype wire

/* bench/avl_mem_model.sv */
// ***************************************************************************
// Avalon memory model for the playback buffer testbench
// pseudo-random avl_ready, write storage, read return after 3 cycles
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

module avl_mem_model import dacfifo_pkg::*; #(
  parameter logic [31:0] SEED = 32'h9ef1_3a74
) (
  input  logic       dac_clk,
  input  logic       avl_reset,
  input  avl_addr_t  avl_address,
  input  logic       avl_read,
  input  logic       avl_write,
  input  avl_word_t  avl_writedata,
  output logic       avl_ready,
  output avl_word_t  avl_readdata,
  output logic       avl_readdata_valid
);

  localparam int DEPTH = 1 << $bits(avl_addr_t);

  avl_word_t    mem [DEPTH];
  avl_word_t    pipe_data [3];
  logic [2:0]   pipe_valid;
  logic [31:0]  lfsr;
  logic         ready_next;

  function automatic logic draw_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  initial begin
    lfsr = SEED;
    // unwritten words carry their own address
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = {4{22'h2a5a5a, avl_addr_t'(i)}};
    end
    pipe_valid = '0;
    avl_ready = 1'b0;
    avl_readdata = '0;
    avl_readdata_valid = 1'b0;
  end

  always @(posedge dac_clk) begin
    if (avl_reset) begin
      pipe_valid = '0;
    end else begin
      if (avl_write && avl_ready) begin
        mem[avl_address] = avl_writedata;
      end
      pipe_valid = {pipe_valid[1:0], avl_read && avl_ready};
      pipe_data[2] = pipe_data[1];
      pipe_data[1] = pipe_data[0];
      pipe_data[0] = mem[avl_address];
    end
    // ready in about three of four cycles
    ready_next = draw_bit() | draw_bit();
    #1;
    avl_ready = ready_next;
    avl_readdata_valid = pipe_valid[2];
    avl_readdata = pipe_data[2];
  end

endmodule

`default_nettype wire

/* bench/avl_dacfifo_tb.sv */
// ***************************************************************************
// testbench of the DAC playback buffer
// clock and reset, LFSR stimulus, queue reference model,
// compare tasks, bus and playback monitors, watchdog
// ***************************************************************************

`timescale 1ns/100ps
`default_nettype none

`include "dacfifo_cfg.svh"

module avl_dacfifo_tb import dacfifo_pkg::*; ();

  localparam int NUM_XFERS = 8;
  localparam int WATCHDOG_CYCLES = NUM_XFERS * 2000 + 100;

  logic       dac_clk;
  logic       avl_reset;
  logic       dma_valid;
  sample_t    dma_data;
  logic       dma_ready;
  logic       dma_xfer_req;
  logic       dma_xfer_last;
  logic       dac_valid;
  sample_t    dac_data;
  logic       dac_dunf;
  logic       dac_xfer_out;
  avl_addr_t  avl_address;
  logic       avl_read;
  logic       avl_write;
  avl_word_t  avl_writedata;
  logic       avl_ready;
  avl_word_t  avl_readdata;
  logic       avl_readdata_valid;

  logic [31:0] lfsr = 32'h9ef1_3a74;
  logic [2:0]  dac_density = 3'd4;
  int          error_count = 0;

  // reference model, samples of the current and the playing waveform
  sample_t    wave[$];
  sample_t    play_wave[$];
  logic       last_sent = 1'b0;
  int         wr_idx = 0;
  int         words_written = 0;
  int         play_idx = 0;
  int         played = 0;

  // monitor state of the previous clock edge
  logic       hold_q = 1'b0;
  logic       read_q;
  logic       write_q;
  avl_addr_t  addr_q;
  avl_word_t  wdata_q;
  logic       valid_q = 1'b0;
  logic       play_q = 1'b0;
  sample_t    data_q;

  avl_dacfifo avl_dacfifo_i (.*);

  avl_mem_model mem_model (
    .dac_clk            (dac_clk),
    .avl_reset          (avl_reset),
    .avl_address        (avl_address),
    .avl_read           (avl_read),
    .avl_write          (avl_write),
    .avl_writedata      (avl_writedata),
    .avl_ready          (avl_ready),
    .avl_readdata       (avl_readdata),
    .avl_readdata_valid (avl_readdata_valid)
  );

  initial begin
    dac_clk = 1'b0;
    forever #5 dac_clk = ~dac_clk;
  end

  // ************************************************************************
  // helpers and compare tasks
  // ************************************************************************

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] draw_bits(input int n);
    logic [63:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val = {val[62:0], fb};
    end
    return val;
  endfunction

  task automatic stop_with_error(input string what);
    error_count++;
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input avl_word_t got, input avl_word_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input avl_addr_t got, input avl_addr_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // one clock, beat taken at the edge, new dac_valid just after it
  task automatic step_cycle(output logic beat);
    @(posedge dac_clk);
    beat = dma_valid && dma_ready;
    #1;
    dac_valid = (draw_bits(2) < dac_density);
  endtask

  task automatic send_transfer(input int len);
    int sent;
    logic beat;
    sample_t next_sample;
    sent = 0;
    wave.delete();
    wr_idx = 0;
    words_written = 0;
    last_sent = 1'b0;
    next_sample = sample_t'(draw_bits(64));
    dma_xfer_req = 1'b1;
    while (sent < len) begin
      // one gap in four
      dma_valid = (draw_bits(2) != 0);
      dma_data = next_sample;
      dma_xfer_last = (sent == len - 1);
      step_cycle(beat);
      if (beat) begin
        if (sent == 0) begin
          check_bit("dac_xfer_out", dac_xfer_out, 1'b0);
        end
        wave.push_back(next_sample);
        last_sent = (sent == len - 1);
        sent++;
        next_sample = sample_t'(draw_bits(64));
      end
    end
    dma_valid = 1'b0;
    dma_xfer_last = 1'b0;
    dma_xfer_req = 1'b0;
  endtask

  // ************************************************************************
  // monitors
  // ************************************************************************

  always @(posedge dac_clk) begin : bus_monitor
    if (!avl_reset) begin
      if (avl_read && avl_write) begin
        stop_with_error("avl_read and avl_write are high in the same cycle");
      end
      if (hold_q) begin
        check_bit("avl_read", avl_read, read_q);
        check_bit("avl_write", avl_write, write_q);
        check_addr("avl_address", avl_address, addr_q);
        check_word("avl_writedata", avl_writedata, wdata_q);
      end
    end
    hold_q = (avl_read || avl_write) && !avl_ready && !avl_reset;
    read_q = avl_read;
    write_q = avl_write;
    addr_q = avl_address;
    wdata_q = avl_writedata;
  end

  always @(posedge dac_clk) begin : write_monitor
    avl_word_t exp_word;
    if (!avl_reset && avl_write && avl_ready) begin
      check_addr("avl_address", avl_address,
                 avl_addr_t'(`DACFIFO_BASE_ADDRESS + words_written));
      if (wave.size() > wr_idx + 1) begin
        exp_word = {wave[wr_idx + 1], wave[wr_idx]};
      end else if (wave.size() == wr_idx + 1 && last_sent) begin
        // odd length, upper half empty
        exp_word = avl_word_t'(wave[wr_idx]);
      end else begin
        stop_with_error("memory write issued before its DMA samples were accepted");
      end
      check_word("avl_writedata", avl_writedata, exp_word);
      wr_idx += 2;
      words_written++;
    end
  end

  always @(posedge dac_clk) begin : dac_monitor
    if (avl_reset) begin
      valid_q = 1'b0;
      play_q = 1'b0;
    end else begin
      if (valid_q && play_q && !dac_dunf) begin
        check_sample("dac_data", dac_data, play_wave[play_idx]);
        play_idx = (play_idx + 1) % play_wave.size();
        played++;
      end else begin
        // dac_data holds unless a sample was taken
        check_sample("dac_data", dac_data, data_q);
        if (!(valid_q && play_q)) begin
          check_bit("dac_dunf", dac_dunf, 1'b0);
        end
      end
      if (dac_xfer_out && !play_q) begin
        if (!last_sent || words_written != (wave.size() + 1) / 2) begin
          stop_with_error("playback started before the whole waveform was written");
        end
        play_wave = wave;
        play_idx = 0;
      end
      valid_q = dac_valid;
      play_q = dac_xfer_out;
    end
    data_q = dac_data;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge dac_clk);
    stop_with_error("timeout, the transfers and playback did not finish in time");
  end

  // ************************************************************************
  // stimulus
  // ************************************************************************

  initial begin
    int len;
    logic beat;
    avl_reset = 1'b1;
    dma_valid = 1'b0;
    dma_data = '0;
    dma_xfer_req = 1'b0;
    dma_xfer_last = 1'b0;
    dac_valid = 1'b0;
    repeat (5) @(posedge dac_clk);
    #1;
    avl_reset = 1'b0;

    // idle, beats offered without a transfer request
    dma_valid = 1'b1;
    dma_data = sample_t'(draw_bits(64));
    repeat (8) begin
      step_cycle(beat);
      if (beat) begin
        stop_with_error("a DMA beat was accepted before dma_xfer_req rose");
      end
      check_bit("dma_ready", dma_ready, 1'b0);
      check_bit("avl_write", avl_write, 1'b0);
      check_bit("avl_read", avl_read, 1'b0);
      check_bit("dac_xfer_out", dac_xfer_out, 1'b0);
      check_bit("dac_dunf", dac_dunf, 1'b0);
    end
    dma_valid = 1'b0;

    for (int t = 0; t < NUM_XFERS; t++) begin
      // lengths 5 to 40, odd and even in turn
      len = 5 + int'(draw_bits(6) % 36);
      if ((len % 2) != (t % 2)) begin
        len = (len < 40) ? len + 1 : len - 1;
      end
      dac_density = 3'(draw_bits(2)) + 3'd1;
      send_transfer(len);
      played = 0;
      // more than two rounds of the waveform
      while (played < 2 * len + 1) begin
        step_cycle(beat);
      end
    end
    repeat (10) step_cycle(beat);

    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/dacfifo_pkg.sv
logic/avl_req_if.sv
logic/dma_wr_side.sv
logic/avl_port_arbiter.sv
logic/dac_rd_side.sv
logic/avl_dacfifo.sv
bench/avl_mem_model.sv
bench/avl_dacfifo_tb.sv

/* Bender.yml */
package:
  name: avl_dacfifo

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dacfifo_pkg.sv
      - logic/avl_req_if.sv
      - logic/dma_wr_side.sv
      - logic/avl_port_arbiter.sv
      - logic/dac_rd_side.sv
      - logic/avl_dacfifo.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/avl_mem_model.sv
      - bench/avl_dacfifo_tb.sv
